// ==== Makefile ====
SIM = obj_dir/VexeUnitTb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): vlog.f source/*.sv verification/exeUnitTb.sv
	verilator --binary --timing -j 0 --top-module exeUnitTb -Mdir obj_dir -f vlog.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// ==== source/adder64.sv ====
// Adder/subtractor for the execute stage, with condition flags.
// The caller inverts y for subtraction and raises sub as the carry-in.
`timescale 1ns/1ns

module adder64
    import datapathPkg::*;
(
    input  logic [XLEN-1:0] x,
    input  logic [XLEN-1:0] y,
    input  logic            sub,
    output logic [XLEN-1:0] sum,
    output logic            carryFlag,
    output logic            overflowFlag,
    output logic            signFlag,
    output logic            zeroFlag
);

    logic carryOut;

    assign {carryOut, sum} = {1'b0, x} + {1'b0, y} + {{XLEN{1'b0}}, sub};

    assign carryFlag    = carryOut ^ sub; // reads as borrow on subtract
    // same-sign inputs with a sign change in the sum
    assign overflowFlag = (x[XLEN-1] == y[XLEN-1]) && (sum[XLEN-1] != x[XLEN-1]);
    assign signFlag     = sum[XLEN-1];
    assign zeroFlag     = ~|sum;

endmodule

// ==== source/aluExecute.sv ====
// Combinational functional units of the execute stage.
// Works on the registered decode outputs and selects the raw result;
// word results leave here unextended, the result stage fixes bits 63:32.
`timescale 1ns/1ns

module aluExecute
    import aluOpPkg::*, datapathPkg::*;
(
    input  unitE            unit,
    input  logic            subtract,
    input  logic            signedOp,
    input  logic            arithShift,
    input  logic            shiftRight,
    input  logic            wordOp,
    input  mulOpE           mulOp,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] rawResult,
    output logic            adderZero
);

    logic [XLEN-1:0]       adderB;
    logic [XLEN-1:0]       sum;
    logic                  carryFlag;
    logic                  overflowFlag;
    logic                  signFlag;
    logic [SHAMT_BITS-1:0] shamt;
    logic [XLEN-1:0]       shiftIn;
    logic [XLEN-1:0]       shiftOut;
    logic [XLEN-1:0]       cmpOut;
    logic                  mulSignA;
    logic                  mulSignB;
    logic [2*XLEN-1:0]     product;
    logic [XLEN-1:0]       mulOut;
    logic [XLEN-1:0]       divA;
    logic [XLEN-1:0]       divB;
    logic [XLEN-1:0]       quotient;
    logic [XLEN-1:0]       remainder;

    function automatic logic [XLEN-1:0] extendWord(input logic [WLEN-1:0] w, input logic sext);
        return {{(XLEN-WLEN){sext & w[WLEN-1]}}, w};
    endfunction

    assign adderB = b ^ {XLEN{subtract}};

    adder64 adder (
        .x            (a),
        .y            (adderB),
        .sub          (subtract),
        .sum          (sum),
        .carryFlag    (carryFlag),
        .overflowFlag (overflowFlag),
        .signFlag     (signFlag),
        .zeroFlag     (adderZero)
    );

    // word shifts run on the extended low half, only bits 31:0 matter
    assign shamt   = wordOp ? SHAMT_BITS'(b[SHAMTW_BITS-1:0]) : b[SHAMT_BITS-1:0];
    assign shiftIn = wordOp ? extendWord(a[WLEN-1:0], arithShift) : a;

    always_comb begin
        if (!shiftRight) begin
            shiftOut = shiftIn << shamt;
        end else if (arithShift) begin
            shiftOut = $signed(shiftIn) >>> shamt;
        end else begin
            shiftOut = shiftIn >> shamt;
        end
    end

    assign cmpOut = {{(XLEN-1){1'b0}}, signedOp ? (overflowFlag ^ signFlag) : carryFlag};

    // single-cycle multiplier on sign- or zero-extended operands
    assign mulSignA = (mulOp == mulHighSu) || (mulOp == mulHighSs);
    assign mulSignB = (mulOp == mulHighSs);
    assign product  = {{XLEN{mulSignA & a[XLEN-1]}}, a} * {{XLEN{mulSignB & b[XLEN-1]}}, b};
    assign mulOut   = (mulOp == mulLow) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

    // word divides reuse the 64-bit path on extended operands
    assign divA = wordOp ? extendWord(a[WLEN-1:0], signedOp) : a;
    assign divB = wordOp ? extendWord(b[WLEN-1:0], signedOp) : b;

    always_comb begin
        if (divB == '0) begin
            quotient  = '1;
            remainder = divA;
        end else if (signedOp && divA == {1'b1, {(XLEN-1){1'b0}}} && divB == '1) begin
            quotient  = divA; // most negative by minus one
            remainder = '0;
        end else if (signedOp) begin
            quotient  = $signed(divA) / $signed(divB);
            remainder = $signed(divA) % $signed(divB);
        end else begin
            quotient  = divA / divB;
            remainder = divA % divB;
        end
    end

    always_comb begin
        case (unit)
            unitAdd:   rawResult = sum;
            unitAnd:   rawResult = a & b;
            unitOr:    rawResult = a | b;
            unitXor:   rawResult = a ^ b;
            unitShift: rawResult = shiftOut;
            unitPassB: rawResult = b;
            unitCmp:   rawResult = cmpOut;
            unitMul:   rawResult = mulOut;
            unitDiv:   rawResult = quotient;
            unitRem:   rawResult = remainder;
            default:   rawResult = sum;
        endcase
    end

endmodule

// ==== source/aluOpPkg.sv ====
// Operation encodings for the integer execute stage.
// Import into decode, execute and the testbench to share the opcode,
// multiply variant and functional-unit selector types.
package aluOpPkg;

    localparam int ALU_OP_BITS = 5;
    localparam int MUL_OP_BITS = 2;
    localparam int UNIT_BITS   = 4;

    // bit 4 set means a 32-bit word operation
    typedef enum logic [ALU_OP_BITS-1:0] {
        aluAdd   = 5'b00000,
        aluSll   = 5'b00001,
        aluSlt   = 5'b00010,
        aluSltu  = 5'b00011,
        aluXor   = 5'b00100,
        aluSrl   = 5'b00101,
        aluOr    = 5'b00110,
        aluAnd   = 5'b00111,
        aluSub   = 5'b01000,
        aluMul   = 5'b01001,
        aluDivu  = 5'b01010,
        aluDiv   = 5'b01011,
        aluRemu  = 5'b01100,
        aluSra   = 5'b01101,
        aluRem   = 5'b01110,
        aluPassB = 5'b01111, // lui
        aluAddw  = 5'b10000,
        aluSllw  = 5'b10001,
        aluSrlw  = 5'b10101,
        aluSubw  = 5'b11000,
        aluMulw  = 5'b11001,
        aluDivuw = 5'b11010,
        aluDivw  = 5'b11011,
        aluRemuw = 5'b11100,
        aluSraw  = 5'b11101,
        aluRemw  = 5'b11110
    } aluOpE;

    // which half of the product, and operand signedness for the high half
    typedef enum logic [MUL_OP_BITS-1:0] {
        mulLow    = 2'b00,
        mulHighUu = 2'b01,
        mulHighSu = 2'b10,
        mulHighSs = 2'b11
    } mulOpE;

    typedef enum logic [UNIT_BITS-1:0] {
        unitAdd   = 4'd0,
        unitAnd   = 4'd1,
        unitOr    = 4'd2,
        unitXor   = 4'd3,
        unitShift = 4'd4,
        unitPassB = 4'd5,
        unitCmp   = 4'd6,
        unitMul   = 4'd7,
        unitDiv   = 4'd8,
        unitRem   = 4'd9
    } unitE;

endpackage

// ==== source/datapathPkg.sv ====
// Datapath widths for the RV64 integer execute stage.
// Imported by every datapath module and by the testbench.
package datapathPkg;

    // full register width and the word-op width
    localparam int XLEN = 64;
    localparam int WLEN = 32;

    // shift amount widths for 64-bit and word shifts
    localparam int SHAMT_BITS  = 6;
    localparam int SHAMTW_BITS = 5;

endpackage

// ==== source/exeUnit.sv ====
// Integer execute stage of the RV64 core.
// One operation per cycle on issueValid; result and zero come back with
// resultValid two clock edges later. No back-pressure.
`timescale 1ns/1ns

module exeUnit
    import aluOpPkg::*, datapathPkg::*;
(
    input  logic            clk,
    input  logic            rstN,
    input  logic            issueValid,
    input  aluOpE           aluOp,
    input  mulOpE           mulOp,
    input  logic [XLEN-1:0] operandA,
    input  logic [XLEN-1:0] operandB,
    output logic            resultValid,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic            decValid;
    unitE            unit;
    logic            subtract;
    logic            signedOp;
    logic            arithShift;
    logic            shiftRight;
    logic            wordOp;
    mulOpE           decMulOp;
    logic [XLEN-1:0] decA;
    logic [XLEN-1:0] decB;
    logic [XLEN-1:0] rawResult;
    logic            adderZero;

    opDecode decode (
        .clk, .rstN, .issueValid, .aluOp, .mulOp, .operandA, .operandB,
        .decValid, .unit, .subtract, .signedOp, .arithShift, .shiftRight,
        .wordOp, .decMulOp, .decA, .decB
    );

    // stage 2 compute, no register
    aluExecute execute (
        .unit, .subtract, .signedOp, .arithShift, .shiftRight, .wordOp,
        .mulOp     (decMulOp),
        .a         (decA),
        .b         (decB),
        .rawResult,
        .adderZero
    );

    resultStage writeback (
        .clk, .rstN, .decValid, .wordOp, .rawResult, .adderZero,
        .resultValid, .result, .zero
    );

endmodule

// ==== source/opDecode.sv ====
// First pipeline stage of the execute unit.
// Turns the operation code into functional-unit controls and captures
// them together with the operands on every issued cycle.
`timescale 1ns/1ns

module opDecode
    import aluOpPkg::*, datapathPkg::*;
(
    input  logic            clk,
    input  logic            rstN,
    input  logic            issueValid,
    input  aluOpE           aluOp,
    input  mulOpE           mulOp,
    input  logic [XLEN-1:0] operandA,
    input  logic [XLEN-1:0] operandB,
    output logic            decValid,
    output unitE            unit,
    output logic            subtract,
    output logic            signedOp,
    output logic            arithShift,
    output logic            shiftRight,
    output logic            wordOp,
    output mulOpE           decMulOp,
    output logic [XLEN-1:0] decA,
    output logic [XLEN-1:0] decB
);

    unitE unitNext;
    logic subNext;
    logic signedNext;
    logic arithNext;
    logic rightNext;
    logic wordNext;

    always_comb begin
        unitNext   = unitAdd;
        subNext    = 1'b0;
        signedNext = 1'b0;
        arithNext  = 1'b0;
        rightNext  = 1'b0;
        wordNext   = aluOp[4];
        case (aluOp)
            aluAdd, aluAddw: unitNext = unitAdd;
            aluSub, aluSubw: begin
                unitNext = unitAdd;
                subNext  = 1'b1;
            end
            aluSll, aluSllw: unitNext = unitShift;
            aluSrl, aluSrlw: begin
                unitNext  = unitShift;
                rightNext = 1'b1;
            end
            aluSra, aluSraw: begin
                unitNext  = unitShift;
                rightNext = 1'b1;
                arithNext = 1'b1;
            end
            aluSlt: begin
                unitNext   = unitCmp;
                subNext    = 1'b1;
                signedNext = 1'b1;
            end
            aluSltu: begin
                unitNext = unitCmp;
                subNext  = 1'b1; // borrow gives the unsigned compare
            end
            aluXor:            unitNext = unitXor;
            aluOr:             unitNext = unitOr;
            aluAnd:            unitNext = unitAnd;
            aluPassB:          unitNext = unitPassB;
            aluMul, aluMulw:   unitNext = unitMul;
            aluDivu, aluDivuw: unitNext = unitDiv;
            aluDiv, aluDivw: begin
                unitNext   = unitDiv;
                signedNext = 1'b1;
            end
            aluRemu, aluRemuw: unitNext = unitRem;
            aluRem, aluRemw: begin
                unitNext   = unitRem;
                signedNext = 1'b1;
            end
            default: begin
                unitNext = unitAdd; // unknown code runs as add
                wordNext = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= issueValid;
        end
    end

    // payload only moves on an issue
    always_ff @(posedge clk) begin
        if (issueValid) begin
            unit       <= unitNext;
            subtract   <= subNext;
            signedOp   <= signedNext;
            arithShift <= arithNext;
            shiftRight <= rightNext;
            wordOp     <= wordNext;
            decMulOp   <= mulOp;
            decA       <= operandA;
            decB       <= operandB;
        end
    end

endmodule

// ==== source/resultStage.sv ====
// Output stage of the execute unit.
// Sign-extends word results and registers result, zero flag and valid.
`timescale 1ns/1ns

module resultStage
    import datapathPkg::*;
(
    input  logic            clk,
    input  logic            rstN,
    input  logic            decValid,
    input  logic            wordOp,
    input  logic [XLEN-1:0] rawResult,
    input  logic            adderZero,
    output logic            resultValid,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic [XLEN-1:0] extResult;

    // bit 31 fills the upper half for word ops
    assign extResult = wordOp ? {{(XLEN-WLEN){rawResult[WLEN-1]}}, rawResult[WLEN-1:0]}
                              : rawResult;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            result      <= '0;
            zero        <= 1'b0;
        end else begin
            resultValid <= decValid;
            if (decValid) begin // hold on bubbles
                result <= extResult;
                zero   <= adderZero;
            end
        end
    end

endmodule

// ==== verification/aluTests.txt ====
# columns: aluOp mulOp operandA operandB result zero, all in hex
# zero is the adder flag, a-b for sub, slt and sltu and a+b for the rest
00 0 0000000000000005 0000000000000003 0000000000000008 0
00 0 ffffffffffffffff 0000000000000001 0000000000000000 1
08 0 0000000000000010 0000000000000003 000000000000000d 0
08 0 123456789abcdef0 123456789abcdef0 0000000000000000 1
07 0 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 0f000f000f000f00 0
06 0 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f ff0fff0fff0fff0f 0
04 0 0000000000000001 ffffffffffffffff fffffffffffffffe 1
0f 0 0000000000000000 0000000012345000 0000000012345000 0
10 0 000000007fffffff 0000000000000001 ffffffff80000000 0
18 0 0000000000000000 0000000000000001 ffffffffffffffff 0
01 0 0000000000000001 000000000000003f 8000000000000000 0
01 0 0000000000000003 0000000000000104 0000000000000030 0
05 0 8000000000000000 000000000000003f 0000000000000001 0
0d 0 ff00000000000000 ffffffffffffff48 ffff000000000000 0
11 0 0000000000000001 000000000000003f ffffffff80000000 0
15 0 ffffffff80000000 0000000000000004 0000000008000000 0
1d 0 0000000080000000 0000000000000004 fffffffff8000000 0
02 0 8000000000000000 7fffffffffffffff 0000000000000001 0
02 0 7fffffffffffffff 8000000000000000 0000000000000000 0
02 0 ffffffffffffffff ffffffffffffffff 0000000000000000 1
03 0 7fffffffffffffff 8000000000000000 0000000000000001 0
03 0 8000000000000000 7fffffffffffffff 0000000000000000 0
09 0 ffffffffffffffff 8000000000000000 8000000000000000 0
09 1 ffffffffffffffff 8000000000000000 7fffffffffffffff 0
09 2 ffffffffffffffff 8000000000000000 ffffffffffffffff 0
09 3 ffffffffffffffff 8000000000000000 0000000000000000 0
09 3 fffffffffffffffe 8000000000000000 0000000000000001 0
19 0 00000001ffffffff 0000000000000002 fffffffffffffffe 0
0b 0 fffffffffffffff9 0000000000000002 fffffffffffffffd 0
0e 0 fffffffffffffff9 0000000000000002 ffffffffffffffff 0
0a 0 fffffffffffffff9 0000000000000002 7ffffffffffffffc 0
0c 0 fffffffffffffff9 0000000000000002 0000000000000001 0
0b 0 0000000000000005 0000000000000000 ffffffffffffffff 0
0e 0 0000000000000005 0000000000000000 0000000000000005 0
0c 0 fffffffffffffff9 0000000000000000 fffffffffffffff9 0
0b 0 8000000000000000 ffffffffffffffff 8000000000000000 0
0e 0 8000000000000000 ffffffffffffffff 0000000000000000 0
1b 0 ffffffff80000000 00000000ffffffff ffffffff80000000 0
1b 0 0000000000000007 ffffffff00000000 ffffffffffffffff 0
1e 0 00000000fffffff9 0000000100000000 fffffffffffffff9 0
1a 0 00000000fffffffe 0000000000000002 000000007fffffff 0
1c 0 00000000ffffffff 0000000000000010 000000000000000f 0

// ==== verification/exeUnitTb.sv ====
// Testbench for the integer execute stage.
// Reads one test per line from the tests file, issues them with random bubbles
// and checks each result, zero flag and latency in issue order.
`timescale 1ns/1ns

module exeUnitTb
    import aluOpPkg::*, datapathPkg::*;
();

    localparam int    PERIOD    = 40;
    localparam int    LATENCY   = 2; // edges from issue to resultValid
    localparam string TEST_FILE = "verification/aluTests.txt";

    logic            clk;
    logic            rstN;
    logic            issueValid;
    aluOpE           aluOp;
    mulOpE           mulOp;
    logic [XLEN-1:0] operandA;
    logic [XLEN-1:0] operandB;
    logic            resultValid;
    logic [XLEN-1:0] result;
    logic            zero;

    // tests as read from the file
    logic [4:0]      testOp[$];
    logic [1:0]      testMul[$];
    logic [XLEN-1:0] testA[$];
    logic [XLEN-1:0] testB[$];
    logic [XLEN-1:0] testResult[$];
    logic            testZero[$];

    // outstanding issues, oldest first
    logic [XLEN-1:0] expResult[$];
    logic            expZero[$];
    int              expCycle[$];
    int              expIndex[$];

    int errorCount = 0;
    int cycle = 0;
    bit loaded = 1'b0;

    exeUnit dut (
        .clk, .rstN, .issueValid, .aluOp, .mulOp, .operandA, .operandB,
        .resultValid, .result, .zero
    );

    always #(PERIOD/2) clk = ~clk;

    task automatic loadTests();
        int              fd;
        int              count;
        string           line;
        logic [4:0]      op;
        logic [1:0]      mv;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic            z;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test file %s", TEST_FILE);
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                count = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    count = $sscanf(line, "%h %h %h %h %h %h", op, mv, a, b, res, z);
                    if (count == 6) begin
                        testOp.push_back(op);
                        testMul.push_back(mv);
                        testA.push_back(a);
                        testB.push_back(b);
                        testResult.push_back(res);
                        testZero.push_back(z);
                    end else begin
                        $display("Malformed line in the test file: %s", line);
                        errorCount++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runTests();
        int idx;
        idx = 0;
        while (idx < testOp.size()) begin
            if ($urandom % 4 == 0) begin
                issueValid = 1'b0; // bubble
            end else begin
                issueValid = 1'b1;
                aluOp      = aluOpE'(testOp[idx]);
                mulOp      = mulOpE'(testMul[idx]);
                operandA   = testA[idx];
                operandB   = testB[idx];
                expResult.push_back(testResult[idx]);
                expZero.push_back(testZero[idx]);
                expCycle.push_back(cycle);
                expIndex.push_back(idx);
                idx++;
            end
            @(negedge clk);
        end
        issueValid = 1'b0;
    endtask

    task automatic checkResult();
        logic [XLEN-1:0] wantResult;
        logic            wantZero;
        int              issued;
        int              idx;
        wantResult = expResult.pop_front();
        wantZero   = expZero.pop_front();
        issued     = expCycle.pop_front();
        idx        = expIndex.pop_front();
        if (cycle - issued != LATENCY) begin
            $display("Test %0d came back %0d edges after its issue instead of %0d",
                     idx, cycle - issued, LATENCY);
            errorCount++;
        end
        if (result !== wantResult) begin
            $display("Error: time %0t test %0d result expected %h got %h",
                     $time, idx, wantResult, result);
            errorCount++;
        end
        if (zero !== wantZero) begin
            $display("Error: time %0t test %0d zero expected %b got %b",
                     $time, idx, wantZero, zero);
            errorCount++;
        end
    endtask

    // up to LATENCY+2 edges for the last items to come out
    task automatic drainResults();
        int waited;
        waited = 0;
        while (expResult.size() != 0 && waited < LATENCY + 2) begin
            @(negedge clk);
            waited++;
        end
        if (expResult.size() != 0) begin
            $display("%0d issued tests never produced a result", expResult.size());
            errorCount++;
        end
    endtask

    task automatic finishRun();
        $display("Errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            if (resultValid !== 1'b0) begin
                $display("resultValid was high while reset was active at %0t", $time);
                errorCount++;
            end
        end else if (resultValid) begin
            if (expResult.size() == 0) begin
                $display("resultValid was high at %0t with no test outstanding", $time);
                errorCount++;
            end else begin
                checkResult();
            end
        end
        cycle++; // edges seen so far
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (testOp.size() * 2 + 20) * PERIOD;
        #(limit);
        $display("Timeout: the run did not finish within %0d ns", limit);
        errorCount++;
        finishRun();
    end

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        issueValid = 1'b0;
        aluOp      = aluAdd;
        mulOp      = mulLow;
        operandA   = '0;
        operandB   = '0;
        void'($urandom(29));
        loadTests();
        loaded = 1'b1;
        if (testOp.size() == 0) begin
            $display("No tests were read, nothing was run");
            errorCount++;
        end else begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            rstN = 1'b1;
            runTests();
            drainResults();
        end
        finishRun();
    end

endmodule

// ==== vlog.f ====
source/aluOpPkg.sv
source/datapathPkg.sv
source/adder64.sv
source/opDecode.sv
source/aluExecute.sv
source/resultStage.sv
source/exeUnit.sv
verification/exeUnitTb.sv
